// File: mipsCore.f
+incdir+testbench
src/mipsPkg.sv
src/pcUnit.sv
src/instrMemory.sv
src/controlUnit.sv
src/regFile.sv
src/alu.sv
src/dataMemory.sv
src/mipsCore.sv
testbench/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f mipsCore.f \
    --top-module mipsCoreTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  mipsPkg::aluOpT op,
    output logic [31:0]    result,
    output logic           zero
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mipsPkg::aluAdd: begin
                result = a + b;
            end
            mipsPkg::aluSub: begin
                result = a - b;
            end
            mipsPkg::aluAnd: begin
                result = a & b;
            end
            mipsPkg::aluOr: begin
                result = a | b;
            end
            mipsPkg::aluSlt: begin
                result = {31'd0, lessThan};
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  mipsPkg::instrWord  instr,
    output mipsPkg::ctrlT      ctrl,
    output logic [31:0]        imm
);

    logic [5:0]  op;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign op    = instr.rType.op;
    assign funct = instr.rType.funct;
    assign imm16 = instr.iType.imm16;

    assign imm = {{16{imm16[15]}}, imm16};

    always_comb begin
        // Unknown encodings fall through as no-ops
        ctrl       = '0;
        ctrl.aluOp = mipsPkg::aluAdd;
        case (op)
            mipsPkg::opRType: begin
                ctrl.regDest = 1'b1;
                case (funct)
                    mipsPkg::fnAdd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluAdd;
                    end
                    mipsPkg::fnSub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSub;
                    end
                    mipsPkg::fnAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluAnd;
                    end
                    mipsPkg::fnOr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluOr;
                    end
                    mipsPkg::fnSlt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSlt;
                    end
                    mipsPkg::fnJr: begin
                        ctrl.jumpReg = 1'b1;
                    end
                    default: begin
                        ctrl.regDest = 1'b0;
                    end
                endcase
            end
            mipsPkg::opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                // Equality through subtract and zero flag
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsPkg::aluSub;
            end
            mipsPkg::opJ: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl.aluOp = mipsPkg::aluAdd;
            end
        endcase
    end

endmodule

// File: src/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input  logic               clk,
    input  mipsPkg::memWriteT  wr,
    input  logic [7:0]         raddr,
    output logic [31:0]        rdata
);

    logic [31:0] mem [mipsPkg::memWords];

    logic [mipsPkg::memAddrBits-1:0] writeIdx;
    logic [mipsPkg::memAddrBits-1:0] readIdx;

    assign writeIdx = wr.addr[mipsPkg::memAddrBits+1:2];
    assign readIdx  = raddr[mipsPkg::memAddrBits+1:2];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[writeIdx] <= wr.data;
        end
    end

    // Asynchronous read, word granular
    assign rdata = mem[readIdx];

endmodule

// File: src/instrMemory.sv
`timescale 1ns/1ps

module instrMemory (
    input  logic               clk,
    input  mipsPkg::memWriteT  load,
    input  logic [31:0]        pc,
    output mipsPkg::instrWord  instr
);

    logic [31:0] mem [mipsPkg::memWords];

    logic [mipsPkg::memAddrBits-1:0] loadIdx;
    logic [mipsPkg::memAddrBits-1:0] readIdx;

    // Word index from byte address
    assign loadIdx = load.addr[mipsPkg::memAddrBits+1:2];
    assign readIdx = pc[mipsPkg::memAddrBits+1:2];

    // Program load port
    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[loadIdx] <= load.data;
        end
    end

    assign instr = mem[readIdx];

endmodule

// File: src/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  mipsPkg::memWriteT  imemLoad,
    output mipsPkg::commitT    commit
);

    logic [31:0]        pc;
    mipsPkg::instrWord  instr;
    mipsPkg::ctrlT      ctrl;
    logic [31:0]        imm;

    logic [4:0]         writeAddr;
    logic [31:0]        writeData;
    logic               regWe;
    logic [31:0]        rdataA;
    logic [31:0]        rdataB;

    logic [31:0]        aluB;
    logic [31:0]        aluResult;
    logic               aluZero;

    mipsPkg::memWriteT  dmemWr;
    logic [31:0]        dmemRdata;

    pcUnit uPcUnit (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .ctrl     (ctrl),
        .imm      (imm),
        .target   (instr.jType.target26),
        .zero     (aluZero),
        .jumpBase (rdataA),
        .pc       (pc)
    );

    instrMemory uInstrMemory (
        .clk   (clk),
        .load  (imemLoad),
        .pc    (pc),
        .instr (instr)
    );

    controlUnit uControlUnit (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    // Destination is rd for R-type, rt otherwise
    assign writeAddr = ctrl.regDest ? instr.rType.rd : instr.rType.rt;
    assign writeData = ctrl.memToReg ? dmemRdata : aluResult;
    assign regWe     = ctrl.regWrite & run;

    regFile uRegFile (
        .clk    (clk),
        .we     (regWe),
        .waddr  (writeAddr),
        .wdata  (writeData),
        .raddrA (instr.rType.rs),
        .raddrB (instr.rType.rt),
        .rdataA (rdataA),
        .rdataB (rdataB)
    );

    assign aluB = ctrl.aluSrc ? imm : rdataB;

    alu uAlu (
        .a      (rdataA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // Stores only land while running
    assign dmemWr.en   = ctrl.memWrite & run;
    assign dmemWr.addr = aluResult[7:0];
    assign dmemWr.data = rdataB;

    dataMemory uDataMemory (
        .clk   (clk),
        .wr    (dmemWr),
        .raddr (aluResult[7:0]),
        .rdata (dmemRdata)
    );

    // Trace of the instruction executing this cycle
    assign commit.valid   = run;
    assign commit.pc      = pc;
    assign commit.regWe   = regWe && (writeAddr != 5'd0);
    assign commit.regAddr = writeAddr;
    assign commit.regData = writeData;
    assign commit.memWe   = dmemWr.en;
    assign commit.memAddr = dmemWr.addr;
    assign commit.memData = dmemWr.data;

endmodule

// File: src/mipsPkg.sv
package mipsPkg;

    // Memory sizing
    localparam int memWords = 64;
    localparam int memAddrBits = 6;
    localparam logic [31:0] resetPc = 32'h0000_0000;

    // Primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] fnJr  = 6'h08;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Three views of one instruction word
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } iType;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target26;
        } jType;
    } instrWord;

    typedef struct packed {
        logic  regDest;
        logic  aluSrc;
        logic  memToReg;
        logic  regWrite;
        logic  memWrite;
        logic  branch;
        logic  jump;
        logic  jumpReg;
        aluOpT aluOp;
    } ctrlT;

    // Byte address, word aligned
    typedef struct packed {
        logic        en;
        logic [7:0]  addr;
        logic [31:0] data;
    } memWriteT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWe;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWe;
        logic [7:0]  memAddr;
        logic [31:0] memData;
    } commitT;

endpackage

// File: src/pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  mipsPkg::ctrlT      ctrl,
    input  logic [31:0]        imm,
    input  logic [25:0]        target,
    input  logic               zero,
    input  logic [31:0]        jumpBase,
    output logic [31:0]        pc
);

    logic [31:0] pcPlus4;
    logic [31:0] jumpAddr;
    logic [31:0] branchAddr;
    logic [31:0] pcNext;

    assign pcPlus4 = pc + 32'd4;

    // Region of the next instruction, word index from the J field
    assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

    assign branchAddr = pcPlus4 + {imm[29:0], 2'b00};

    always_comb begin
        if (ctrl.jumpReg) begin
            pcNext = jumpBase;
        end else if (ctrl.jump) begin
            pcNext = jumpAddr;
        end else if (ctrl.branch && zero) begin
            pcNext = branchAddr;
        end else begin
            pcNext = pcPlus4;
        end
    end

    // Hold while the core is stopped
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= mipsPkg::resetPc;
        end else if (run) begin
            pc <= pcNext;
        end
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB
);

    logic [31:0] regs [32];

    // Register 0 is never stored
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (raddrA == 5'd0) begin
            rdataA = 32'd0;
        end else begin
            rdataA = regs[raddrA];
        end
    end

    always_comb begin
        if (raddrB == 5'd0) begin
            rdataB = 32'd0;
        end else begin
            rdataB = regs[raddrB];
        end
    end

endmodule

// File: testbench/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

localparam int progWords = 25;
localparam int stepCount = 17;

// Program image, word i sits at byte address 4*i
logic [31:0] progImage [progWords];

// Expected commit for each executed step, in program order
mipsPkg::commitT expTable [stepCount];

function automatic mipsPkg::commitT stepRow(input logic [31:0] pc,
                                            input logic        regWe,
                                            input logic [4:0]  regAddr,
                                            input logic [31:0] regData,
                                            input logic        memWe,
                                            input logic [7:0]  memAddr,
                                            input logic [31:0] memData);
    mipsPkg::commitT row;
    row.valid   = 1'b1;
    row.pc      = pc;
    row.regWe   = regWe;
    row.regAddr = regAddr;
    row.regData = regData;
    row.memWe   = memWe;
    row.memAddr = memAddr;
    row.memData = memData;
    return row;
endfunction

task automatic fillProgramTable();
    // addi $1,5  addi $2,-6  add $3  sub $4  and $5  or $6  slt $7,$2,$1
    progImage[0]  = 32'h2001_0005;
    progImage[1]  = 32'h2002_fffa;
    progImage[2]  = 32'h0022_1820;
    progImage[3]  = 32'h0022_2022;
    progImage[4]  = 32'h0022_2824;
    progImage[5]  = 32'h0022_3025;
    progImage[6]  = 32'h0041_382a;
    // addi $0,7 then sw $4,11($1) and lw $8,16($0)
    progImage[7]  = 32'h2000_0007;
    progImage[8]  = 32'hac24_000b;
    progImage[9]  = 32'h8c08_0010;
    // beq $1,$1,+2 skips two fillers
    progImage[10] = 32'h1021_0002;
    progImage[11] = 32'h2009_0001;
    progImage[12] = 32'h2009_0002;
    // beq $1,$2 falls through, j 0x48
    progImage[13] = 32'h1022_0005;
    progImage[14] = 32'h0800_0012;
    progImage[15] = 32'h2009_0003;
    progImage[16] = 32'h2009_0004;
    progImage[17] = 32'h2009_0005;
    // addi $10,0x5c then jr $10
    progImage[18] = 32'h200a_005c;
    progImage[19] = 32'h0140_0008;
    progImage[20] = 32'h2009_0006;
    progImage[21] = 32'h2009_0007;
    progImage[22] = 32'h2009_0008;
    // add $11,$8,$8  sub $12,$11,$4
    progImage[23] = 32'h0108_5820;
    progImage[24] = 32'h0164_6022;

    expTable[0]  = stepRow(32'h00, 1'b1, 5'd1, 32'h0000_0005, 1'b0, 8'h00, 32'h0);
    expTable[1]  = stepRow(32'h04, 1'b1, 5'd2, 32'hffff_fffa, 1'b0, 8'h00, 32'h0);
    expTable[2]  = stepRow(32'h08, 1'b1, 5'd3, 32'hffff_ffff, 1'b0, 8'h00, 32'h0);
    expTable[3]  = stepRow(32'h0c, 1'b1, 5'd4, 32'h0000_000b, 1'b0, 8'h00, 32'h0);
    expTable[4]  = stepRow(32'h10, 1'b1, 5'd5, 32'h0000_0000, 1'b0, 8'h00, 32'h0);
    expTable[5]  = stepRow(32'h14, 1'b1, 5'd6, 32'hffff_ffff, 1'b0, 8'h00, 32'h0);
    expTable[6]  = stepRow(32'h18, 1'b1, 5'd7, 32'h0000_0001, 1'b0, 8'h00, 32'h0);
    expTable[7]  = stepRow(32'h1c, 1'b0, 5'd0, 32'h0, 1'b0, 8'h00, 32'h0);
    expTable[8]  = stepRow(32'h20, 1'b0, 5'd0, 32'h0, 1'b1, 8'h10, 32'h0000_000b);
    expTable[9]  = stepRow(32'h24, 1'b1, 5'd8, 32'h0000_000b, 1'b0, 8'h00, 32'h0);
    expTable[10] = stepRow(32'h28, 1'b0, 5'd0, 32'h0, 1'b0, 8'h00, 32'h0);
    expTable[11] = stepRow(32'h34, 1'b0, 5'd0, 32'h0, 1'b0, 8'h00, 32'h0);
    expTable[12] = stepRow(32'h38, 1'b0, 5'd0, 32'h0, 1'b0, 8'h00, 32'h0);
    expTable[13] = stepRow(32'h48, 1'b1, 5'd10, 32'h0000_005c, 1'b0, 8'h00, 32'h0);
    expTable[14] = stepRow(32'h4c, 1'b0, 5'd0, 32'h0, 1'b0, 8'h00, 32'h0);
    expTable[15] = stepRow(32'h5c, 1'b1, 5'd11, 32'h0000_0016, 1'b0, 8'h00, 32'h0);
    expTable[16] = stepRow(32'h60, 1'b1, 5'd12, 32'h0000_000b, 1'b0, 8'h00, 32'h0);
endtask

`endif

// File: testbench/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

    localparam int commitTimeout = 20;

    logic               clk;
    logic               rstN;
    logic               run;
    mipsPkg::memWriteT  imemLoad;
    mipsPkg::commitT    commit;

    int                 seed;
    int                 idleCycles;
    int                 pauseCycles;
    int                 pauseStep;
    int                 waited;
    mipsPkg::memWriteT  loadWord;

    `include "programTable.svh"

    mipsCore u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .imemLoad (imemLoad),
        .commit   (commit)
    );

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Commit sampled on the falling edge, idle edges counted
    task automatic waitForCommit(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!commit.valid) begin
            if (cycles >= commitTimeout) begin
                $display("timeout: no valid commit within %0d cycles", commitTimeout);
                $display("Some tests failed");
                $fatal(1, "commit wait timed out");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic compareStep(input int k);
        mipsPkg::commitT want;
        want = expTable[k];
        check($sformatf("step %0d commit.pc", k), commit.pc, want.pc);
        check($sformatf("step %0d commit.regWe", k), 32'(commit.regWe), 32'(want.regWe));
        if (want.regWe) begin
            check($sformatf("step %0d commit.regAddr", k), 32'(commit.regAddr),
                  32'(want.regAddr));
            check($sformatf("step %0d commit.regData", k), commit.regData, want.regData);
        end
        check($sformatf("step %0d commit.memWe", k), 32'(commit.memWe), 32'(want.memWe));
        if (want.memWe) begin
            check($sformatf("step %0d commit.memAddr", k), 32'(commit.memAddr),
                  32'(want.memAddr));
            check($sformatf("step %0d commit.memData", k), commit.memData, want.memData);
        end
    endtask

    // PC must stay put while run is low
    task automatic holdRun(input int cycles, input logic [31:0] heldPc);
        @(posedge clk);
        run <= 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            check("commit.valid while held", 32'(commit.valid), 32'd0);
            check("commit.pc while held", commit.pc, heldPc);
        end
        @(posedge clk);
        run <= 1'b1;
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        run        = 1'b0;
        imemLoad   = '0;
        loadWord   = '0;
        seed       = 32'hadd7;
        waited     = 0;
        pauseStep  = 10;
        fillProgramTable();
        idleCycles  = 1 + ({$random(seed)} % 4);
        pauseCycles = 1 + ({$random(seed)} % 5);

        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check("commit.valid after reset", 32'(commit.valid), 32'd0);

        // Program load with the core stopped
        for (int i = 0; i < progWords; i++) begin
            @(posedge clk);
            loadWord.en   = 1'b1;
            loadWord.addr = 8'(i * 4);
            loadWord.data = progImage[i];
            imemLoad <= loadWord;
            @(negedge clk);
            check("commit.valid during load", 32'(commit.valid), 32'd0);
        end
        @(posedge clk);
        imemLoad <= '0;

        repeat (idleCycles) begin
            @(negedge clk);
            check("commit.valid before run", 32'(commit.valid), 32'd0);
        end
        @(posedge clk);
        run <= 1'b1;

        for (int k = 0; k < stepCount; k++) begin
            if (k == pauseStep) begin
                holdRun(pauseCycles, expTable[k].pc);
            end
            waitForCommit(waited);
            // One commit per clock while running
            check($sformatf("step %0d cycles without commit.valid", k), 32'(waited), 32'd0);
            compareStep(k);
        end
        @(posedge clk);
        run <= 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule
